// ==== rtl/bp_macros.svh ====
// branch predictor sizing: pc width, history length, table depths and pc field positions
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

`define BP_PC_W         32  // pc and target width
`define BP_HIST_W       5   // global history bits, also pht index width
`define BP_PHT_DEPTH    32  // two-bit counters in pattern table

`define BP_BTB_IDX_W    4   // btb index bits
`define BP_BTB_DEPTH    (1 << `BP_BTB_IDX_W)  // 16 btb entries

// pc fields: [1:0] byte offset ignored, index from bit 2, tag from bit 6 up
`define BP_WORD_LSB     2   // lowest pc bit used for any index
`define BP_BTB_TAG_LSB  6   // tag is pc[31:6], index is pc[5:2]

`define BP_PC_STEP      4   // fall-through increment, one rv32 word

`endif

// ==== rtl/bp_types_pkg.sv ====
// branch predictor base types: address, history, index and tag vectors, counter states
`include "bp_macros.svh"

package bp_types_pkg;

  typedef logic [`BP_PC_W-1:0] pc_t;  // pc or branch target
  typedef logic [`BP_HIST_W-1:0] ghr_t;  // newest outcome in bit 0
  typedef logic [`BP_HIST_W-1:0] pht_index_t;  // pc[6:2] xor history
  typedef logic [`BP_BTB_IDX_W-1:0] btb_index_t;  // pc[5:2]
  typedef logic [`BP_PC_W-`BP_BTB_TAG_LSB-1:0] btb_tag_t;  // pc[31:6], 26 bits

  // two-bit saturating counter, msb set means lean taken
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } counter_state_t;

endpackage

// ==== rtl/bp_msg_pkg.sv ====
// branch predictor messages: fetch prediction, resolution, redirect and table updates
package bp_msg_pkg;

  import bp_types_pkg::*;

  typedef struct packed {
    pc_t        next_pc;  // predicted fetch address
    pht_index_t pht_index;  // carried down the pipe for training
  } fetch_pred_t;

  typedef struct packed {
    logic       valid;  // one control-flow instr resolved this cycle
    pc_t        pc;  // pc of the resolved instr
    pc_t        predicted_next_pc;  // what fetch guessed back then
    logic       taken;  // actual outcome
    pc_t        target;  // actual taken target
    logic       is_cond;  // conditional branch
    logic       is_uncond;  // jal / jalr
    pht_index_t pht_index;  // index used at fetch
  } branch_resolve_t;

  typedef struct packed {
    logic valid;  // fetch must restart
    pc_t  pc;  // corrected fetch pc
  } redirect_t;

  typedef struct packed {
    logic       write;  // train counter and shift history
    pht_index_t index;
    logic       taken;
  } pht_update_t;

  typedef struct packed {
    logic write;  // fill btb entry
    pc_t  pc;  // gives index and tag
    pc_t  target;
    logic uncond;  // jump, used regardless of direction guess
  } btb_update_t;

endpackage

// ==== rtl/gshare_direction.sv ====
// gshare direction predictor: global history xor pc into a table of two-bit counters
`timescale 1ns/1ps
`include "bp_macros.svh"

module gshare_direction
  import bp_types_pkg::*, bp_msg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  pc_t         fetch_pc,
  input  pht_update_t update,
  output pht_index_t  pht_index,
  output logic        predict_taken
);

  ghr_t           ghr;  // resolved conditional outcomes only
  counter_state_t pht [`BP_PHT_DEPTH];  // pattern history table
  counter_state_t fetch_ctr;  // counter seen by this fetch

  // one saturating step toward the resolved direction
  function automatic counter_state_t step_counter(counter_state_t cur, logic taken);
    counter_state_t nxt;
    nxt = cur;
    case (cur)
      strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
      weak_not_taken:   nxt = taken ? weak_taken : strong_not_taken;
      weak_taken:       nxt = taken ? strong_taken : weak_not_taken;
      strong_taken:     nxt = taken ? strong_taken : weak_taken;
      default:          nxt = weak_not_taken;  // unreachable, 2-bit enum
    endcase
    return nxt;
  endfunction

  // fetch side, purely combinational
  assign pht_index = fetch_pc[`BP_HIST_W+`BP_WORD_LSB-1:`BP_WORD_LSB] ^ ghr;  // pc[6:2] ^ ghr
  assign fetch_ctr = pht[pht_index];
  assign predict_taken = (fetch_ctr == weak_taken) || (fetch_ctr == strong_taken);

  // training at resolution; a same-cycle fetch still reads the old counter
  always_ff @(posedge clk) begin
    if (reset) begin
      ghr <= '0;
      for (int i = 0; i < `BP_PHT_DEPTH; i++) begin
        pht[i] <= weak_not_taken;  // start just below taken
      end
    end else if (update.write) begin
      pht[update.index] <= step_counter(pht[update.index], update.taken);
      ghr <= {ghr[`BP_HIST_W-2:0], update.taken};  // newest into bit 0
    end
  end

endmodule

// ==== rtl/branch_target_buffer.sv ====
// branch target buffer: direct-mapped, tagged store of taken targets and jump flags
`timescale 1ns/1ps
`include "bp_macros.svh"

module branch_target_buffer
  import bp_types_pkg::*, bp_msg_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  pc_t         fetch_pc,
  input  btb_update_t update,
  output logic        hit,
  output pc_t         target,
  output logic        uncond
);

  logic     valid_q  [`BP_BTB_DEPTH];  // only state cleared by reset
  btb_tag_t tag_q    [`BP_BTB_DEPTH];
  pc_t      target_q [`BP_BTB_DEPTH];
  logic     uncond_q [`BP_BTB_DEPTH];  // entry came from a jump

  btb_index_t fetch_idx;
  btb_tag_t   fetch_tag;
  btb_index_t fill_idx;
  btb_tag_t   fill_tag;

  // pc[5:2] index, pc[31:6] tag, byte offset dropped
  assign fetch_idx = fetch_pc[`BP_BTB_TAG_LSB-1:`BP_WORD_LSB];
  assign fetch_tag = fetch_pc[`BP_PC_W-1:`BP_BTB_TAG_LSB];
  assign fill_idx  = update.pc[`BP_BTB_TAG_LSB-1:`BP_WORD_LSB];
  assign fill_tag  = update.pc[`BP_PC_W-1:`BP_BTB_TAG_LSB];

  // lookup, same cycle as fetch_pc
  assign hit    = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);
  assign target = target_q[fetch_idx];  // meaningful only with hit
  assign uncond = uncond_q[fetch_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (update.write) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  // fill overwrites whatever aliased at this index
  always_ff @(posedge clk) begin
    if (update.write) begin
      tag_q[fill_idx]    <= fill_tag;
      target_q[fill_idx] <= update.target;
      uncond_q[fill_idx] <= update.uncond;
    end
  end

endmodule

// ==== rtl/next_pc_select.sv ====
// next-pc select: picks the predicted fetch pc and judges resolved branches for redirect
`timescale 1ns/1ps
`include "bp_macros.svh"

module next_pc_select
  import bp_types_pkg::*, bp_msg_pkg::*;
(
  input  pc_t             fetch_pc,
  input  pht_index_t      pht_index,
  input  logic            predict_taken,
  input  logic            btb_hit,
  input  pc_t             btb_target,
  input  logic            btb_uncond,
  input  branch_resolve_t resolve,
  output fetch_pred_t     prediction,
  output redirect_t       redirect,
  output pht_update_t     pht_update,
  output btb_update_t     btb_update
);

  pc_t  fall_through;  // fetch_pc + 4
  logic use_target;  // follow btb this cycle
  pc_t  correct_pc;  // where the resolved instr really goes
  logic mispredict;

  // fetch side
  assign fall_through = fetch_pc + pc_t'(`BP_PC_STEP);
  assign use_target   = btb_hit && (btb_uncond || predict_taken);  // jumps ignore counters

  assign prediction.next_pc   = use_target ? btb_target : fall_through;
  assign prediction.pht_index = pht_index;  // passed through for later training

  // resolve side
  assign correct_pc = resolve.taken ? resolve.target : resolve.pc + pc_t'(`BP_PC_STEP);
  assign mispredict = correct_pc != resolve.predicted_next_pc;

  assign redirect.valid = resolve.valid && mispredict;
  assign redirect.pc    = correct_pc;

  // counters learn from conditional branches only
  assign pht_update.write = resolve.valid && resolve.is_cond;
  assign pht_update.index = resolve.pht_index;
  assign pht_update.taken = resolve.taken;

  // any taken control flow fills the btb, not-taken never does
  assign btb_update.write  = resolve.valid && resolve.taken;
  assign btb_update.pc     = resolve.pc;
  assign btb_update.target = resolve.target;
  assign btb_update.uncond = resolve.is_uncond;

endmodule

// ==== rtl/branch_predictor.sv ====
// branch predictor top: gshare direction and btb side by side, next-pc select on top
`timescale 1ns/1ps

module branch_predictor
  import bp_types_pkg::*, bp_msg_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  pc_t             fetch_pc,
  input  branch_resolve_t resolve,
  output fetch_pred_t     prediction,
  output redirect_t       redirect
);

  pht_index_t  pht_index;
  logic        predict_taken;
  logic        btb_hit;
  pc_t         btb_target;
  logic        btb_uncond;
  pht_update_t pht_update;  // training cmd from select
  btb_update_t btb_update;  // fill cmd from select

  gshare_direction u_gshare (
    .clk           (clk),
    .reset         (reset),
    .fetch_pc      (fetch_pc),
    .update        (pht_update),
    .pht_index     (pht_index),
    .predict_taken (predict_taken)
  );

  branch_target_buffer u_btb (
    .clk      (clk),
    .reset    (reset),
    .fetch_pc (fetch_pc),
    .update   (btb_update),
    .hit      (btb_hit),
    .target   (btb_target),
    .uncond   (btb_uncond)
  );

  next_pc_select u_select (
    .fetch_pc      (fetch_pc),
    .pht_index     (pht_index),
    .predict_taken (predict_taken),
    .btb_hit       (btb_hit),
    .btb_target    (btb_target),
    .btb_uncond    (btb_uncond),
    .resolve       (resolve),
    .prediction    (prediction),
    .redirect      (redirect),
    .pht_update    (pht_update),
    .btb_update    (btb_update)
  );

endmodule

// ==== testbench/branch_predictor_props.sv ====
// branch predictor port assertions: redirect qualification, post-reset fall-through, alignment
`timescale 1ns/1ps

module bp_props
  import bp_types_pkg::*, bp_msg_pkg::*;
(
  input logic            clk,
  input logic            reset,
  input pc_t             fetch_pc,
  input branch_resolve_t resolve,
  input fetch_pred_t     prediction,
  input redirect_t       redirect
);

  int assert_failures = 0;  // count of fired assertions

  // redirect only ever answers a resolve
  redirect_needs_resolve: assert property (
    @(posedge clk) disable iff (reset) redirect.valid |-> resolve.valid
  ) else begin
    $error("redirect.valid high without resolve.valid");
    assert_failures++;
  end

  // btb is empty right after reset, so fetch falls through
  fall_through_after_reset: assert property (
    @(posedge clk) $fell(reset) |-> prediction.next_pc == fetch_pc + 32'd4
  ) else begin
    $error("first prediction after reset is not fetch_pc + 4");
    assert_failures++;
  end

  // aligned pc and target give an aligned correction
  redirect_word_aligned: assert property (
    @(posedge clk) disable iff (reset)
      (redirect.valid && resolve.pc[1:0] == 2'b00 && resolve.target[1:0] == 2'b00)
      |-> redirect.pc[1:0] == 2'b00
  ) else begin
    $error("redirect.pc not word aligned");
    assert_failures++;
  end

endmodule

bind branch_predictor bp_props u_props (
  .clk        (clk),
  .reset      (reset),
  .fetch_pc   (fetch_pc),
  .resolve    (resolve),
  .prediction (prediction),
  .redirect   (redirect)
);

// ==== testbench/branch_predictor_tb.sv ====
// branch predictor testbench: table of fetch and resolve steps checked against a reference model
`timescale 1ns/1ps
`include "bp_macros.svh"

module branch_predictor_tb
  import bp_types_pkg::*, bp_msg_pkg::*;
;

  localparam int RESET_TIMEOUT = 20;  // cycles until reset release
  localparam int TABLE_TIMEOUT = 200;  // cycles for the whole table
  localparam int RUN_LIMIT     = 400;  // watchdog
  localparam int RANDOM_STEPS  = 40;

  logic            clk;
  logic            reset;
  pc_t             fetch_pc;
  branch_resolve_t resolve;
  fetch_pred_t     prediction;
  redirect_t       redirect;

  // stimulus table, one entry per step
  string           name_q[$];
  pc_t             fetch_q[$];
  branch_resolve_t res_q[$];
  bit              fixed_q[$];  // row pins the redirect
  redirect_t       exp_redir_q[$];

  // reference model state
  ghr_t     ref_ghr;
  int       ref_ctr    [`BP_PHT_DEPTH];  // 0..3, 2 and up leans taken
  bit       ref_valid  [`BP_BTB_DEPTH];
  btb_tag_t ref_tag    [`BP_BTB_DEPTH];
  pc_t      ref_target [`BP_BTB_DEPTH];
  bit       ref_uncond [`BP_BTB_DEPTH];

  logic [31:0] lcg_state;
  int          pass_count;
  int          fail_count;
  int          error_count;
  int          cycle_count;
  bit          step_ok;
  bit          timed_out;

  branch_predictor dut0 (
    .clk        (clk),
    .reset      (reset),
    .fetch_pc   (fetch_pc),
    .resolve    (resolve),
    .prediction (prediction),
    .redirect   (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    reset    = 1'b1;
    fetch_pc = '0;
    resolve  = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;  // held for 5 cycles
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < RUN_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: simulation still running after %0d cycles", RUN_LIMIT);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // pc[6:2] xor history
  function automatic pht_index_t fetch_index(pc_t pc);
    return pht_index_t'(pc[6:2] ^ ref_ghr);
  endfunction

  function automatic pc_t predict_next_pc(pc_t pc);
    btb_index_t bi;
    bit         lean_taken;
    bit         hit;
    bi         = pc[5:2];
    lean_taken = ref_ctr[fetch_index(pc)] >= 2;
    hit        = ref_valid[bi] && (ref_tag[bi] == pc[31:6]);
    if (hit && (ref_uncond[bi] || lean_taken)) begin
      return ref_target[bi];
    end
    return pc + 32'd4;  // fall through
  endfunction

  function automatic redirect_t expected_redirect(branch_resolve_t r);
    redirect_t e;
    e.pc    = r.taken ? r.target : r.pc + 32'd4;
    e.valid = r.valid && (e.pc != r.predicted_next_pc);
    return e;
  endfunction

  task automatic reset_model();
    ref_ghr = '0;
    for (int i = 0; i < `BP_PHT_DEPTH; i++) begin
      ref_ctr[i] = 1;  // weak not taken
    end
    for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
      ref_valid[i] = 1'b0;
    end
  endtask

  // same effect the dut shows at the following edge
  task automatic train_model(branch_resolve_t r);
    if (r.valid && r.is_cond) begin
      if (r.taken && ref_ctr[r.pht_index] < 3) begin
        ref_ctr[r.pht_index]++;
      end else if (!r.taken && ref_ctr[r.pht_index] > 0) begin
        ref_ctr[r.pht_index]--;
      end
      ref_ghr = {ref_ghr[3:0], r.taken};  // newest in bit 0
    end
    if (r.valid && r.taken) begin
      ref_valid[r.pc[5:2]]  = 1'b1;
      ref_tag[r.pc[5:2]]    = r.pc[31:6];
      ref_target[r.pc[5:2]] = r.target;
      ref_uncond[r.pc[5:2]] = r.is_uncond;
    end
  endtask

  function automatic branch_resolve_t make_resolve(pc_t pc, pc_t pred, logic taken,
                                                   pc_t target, logic is_cond, logic is_uncond);
    branch_resolve_t r;
    r                   = '0;
    r.valid             = 1'b1;
    r.pc                = pc;
    r.predicted_next_pc = pred;
    r.taken             = taken;
    r.target            = target;
    r.is_cond           = is_cond;
    r.is_uncond         = is_uncond;
    return r;  // pht_index filled in when driven
  endfunction

  task automatic add_step(string name, pc_t fpc, branch_resolve_t res, bit fixed,
                          logic exp_valid, pc_t exp_pc);
    redirect_t e;
    e.valid = exp_valid;
    e.pc    = exp_pc;
    name_q.push_back(name);
    fetch_q.push_back(fpc);
    res_q.push_back(res);
    fixed_q.push_back(fixed);
    exp_redir_q.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0]     r0;
    logic [31:0]     r1;
    pc_t             fpc;
    branch_resolve_t res;
    add_step("reset_fetch_a", 32'h0000_0100, '0, 1'b1, 1'b0, '0);  // cold tables
    add_step("reset_fetch_b", 32'h0000_0104, '0, 1'b1, 1'b0, '0);
    add_step("reset_fetch_c", 32'h0000_02a8, '0, 1'b1, 1'b0, '0);
    add_step("reset_fetch_d", 32'h8000_0040, '0, 1'b1, 1'b0, '0);
    add_step("resolve_ok_nt", 32'h100, make_resolve(32'h120, 32'h124, 0, 32'h180, 1, 0),
             1'b1, 1'b0, '0);
    add_step("resolve_bad_t", 32'h104, make_resolve(32'h130, 32'h134, 1, 32'h1c0, 1, 0),
             1'b1, 1'b1, 32'h1c0);
    add_step("resolve_bad_nt", 32'h108, make_resolve(32'h140, 32'h1a0, 0, 32'h1a0, 1, 0),
             1'b1, 1'b1, 32'h144);
    add_step("resolve_ok_jump", 32'h10c, make_resolve(32'h150, 32'h300, 1, 32'h300, 0, 1),
             1'b1, 1'b0, '0);
    add_step("jump_fill", 32'h200, make_resolve(32'h200, 32'h204, 1, 32'h340, 0, 1),
             1'b1, 1'b1, 32'h340);
    add_step("jump_predict", 32'h200, '0, 1'b1, 1'b0, '0);  // model expects 0x340
    for (int k = 0; k < 9; k++) begin
      add_step($sformatf("train_cond_%0d", k), 32'h5c0,
               make_resolve(32'h5c0, 32'h5c4, 1, 32'h700, 1, 0), 1'b1, 1'b1, 32'h700);
    end
    add_step("alias_first", 32'h100, make_resolve(32'h1010, 32'h1014, 1, 32'h1800, 0, 1),
             1'b1, 1'b1, 32'h1800);
    add_step("alias_second", 32'h1010, make_resolve(32'h2010, 32'h2014, 1, 32'h2800, 0, 1),
             1'b1, 1'b1, 32'h2800);
    add_step("alias_evicted", 32'h1010, '0, 1'b1, 1'b0, '0);  // back to pc + 4
    add_step("alias_kept", 32'h2010, '0, 1'b1, 1'b0, '0);
    for (int k = 0; k < RANDOM_STEPS; k++) begin
      r0                    = lcg_next();
      r1                    = lcg_next();
      fpc                   = 32'h100 + ((r0 >> 8) & 32'h3f) * 4;  // 64 words from 0x100
      res                   = '0;
      res.valid             = r1[16];
      res.pc                = 32'h100 + ((r1 >> 8) & 32'h3f) * 4;
      res.is_uncond         = r1[20] & r1[21];  // about one jump in four
      res.is_cond           = !res.is_uncond;
      res.taken             = res.is_uncond | r1[24];
      res.target            = 32'h100 + ((r0 >> 16) & 32'h3f) * 4;
      res.predicted_next_pc = r0[28] ? res.target : res.pc + 32'd4;
      add_step($sformatf("random_%0d", k), fpc, res, 1'b0, 1'b0, '0);
    end
  endtask

  task automatic check_value(string name, string what, logic [63:0] expected,
                             logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: %s expected %0h, actual %0h", name, what, expected, actual);
      error_count++;
      step_ok = 1'b0;
    end
  endtask

  initial begin
    int              waited;
    int              step;
    int              table_cycles;
    pc_t             exp_pc;
    redirect_t       exp_redir;
    branch_resolve_t res;
    pass_count  = 0;
    fail_count  = 0;
    error_count = 0;
    timed_out   = 1'b0;
    lcg_state   = 32'd68;  // seed
    reset_model();
    build_table();
    waited = 0;
    while (reset !== 1'b0 && waited < RESET_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (reset !== 1'b0) begin
      $display("timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
      timed_out = 1'b1;
    end else begin
      step         = 0;
      table_cycles = 0;
      while (step < name_q.size() && table_cycles < TABLE_TIMEOUT) begin
        @(posedge clk);
        table_cycles++;
        res           = res_q[step];
        res.pht_index = fetch_index(res.pc);  // index the branch was fetched with
        fetch_pc <= fetch_q[step];
        resolve  <= res;
        @(negedge clk);  // outputs settled
        step_ok   = 1'b1;
        exp_pc    = predict_next_pc(fetch_q[step]);
        exp_redir = expected_redirect(res);
        check_value(name_q[step], "next_pc", exp_pc, prediction.next_pc);
        check_value(name_q[step], "pht_index", fetch_index(fetch_q[step]),
                    prediction.pht_index);
        check_value(name_q[step], "redirect.valid", exp_redir.valid, redirect.valid);
        if (exp_redir.valid) begin
          check_value(name_q[step], "redirect.pc", exp_redir.pc, redirect.pc);
        end
        if (fixed_q[step]) begin
          check_value(name_q[step], "table redirect.valid", exp_redir_q[step].valid,
                      redirect.valid);
          if (exp_redir_q[step].valid) begin
            check_value(name_q[step], "table redirect.pc", exp_redir_q[step].pc, redirect.pc);
          end
        end
        train_model(res);  // dut updates at the next edge
        if (step_ok) begin
          pass_count++;
        end else begin
          fail_count++;
        end
        $display("%-16s %s", name_q[step], step_ok ? "passed" : "failed");
        step++;
      end
      if (step < name_q.size()) begin
        $display("timeout: stimulus table unfinished after %0d cycles", TABLE_TIMEOUT);
        timed_out = 1'b1;
      end
    end
    $display("%0d tests passed, %0d tests failed, %0d mismatches, %0d assertion failures",
             pass_count, fail_count, error_count, dut0.u_props.assert_failures);
    if (fail_count == 0 && !timed_out && dut0.u_props.assert_failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/bp_types_pkg.sv
rtl/bp_msg_pkg.sv
rtl/gshare_direction.sv
rtl/branch_target_buffer.sv
rtl/next_pc_select.sv
rtl/branch_predictor.sv
testbench/branch_predictor_props.sv
testbench/branch_predictor_tb.sv
